//--- verilog/spmd_pkg.sv
// spmd cluster shared definitions
// sizes, host register map, AXI response codes and state encodings
`default_nettype none

package spmd_pkg;

  localparam int NUM_TILES   = 4;
  localparam int TILE_ID_W   = 2;
  localparam int DMEM_WORDS  = 64;
  localparam int WORD_IDX_W  = 6;
  localparam int DATA_W      = 32;
  localparam int AXI_ADDR_W  = 12;
  localparam int RESET_DEPTH = 3;

  // host byte addresses
  localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL        = 12'h000; // bit 0 run_en
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS      = 12'h004; // done mask in 7:4
  localparam logic [AXI_ADDR_W-1:0] ADDR_CYCLES      = 12'h008;
  localparam logic [AXI_ADDR_W-1:0] ADDR_RESULT_BASE = 12'h010; // plus 4 per tile
  localparam logic [AXI_ADDR_W-1:0] MEM_BASE         = 12'h400; // tile in 9:8, word in 7:2

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  typedef enum logic {
    REQ_STORE,
    REQ_LOAD
  } req_op_e;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_WAIT_TILE,
    BR_WRESP,
    BR_RRESP
  } bridge_state_e;

  typedef enum logic [1:0] {
    T_IDLE,
    T_LOAD_N,
    T_SUM,
    T_DONE
  } tile_state_e;

endpackage

`default_nettype wire

//--- verilog/spmd_tile.sv
// spmd tile
// 64-word data memory with a host port, plus a kernel that sums words 1..n
`timescale 1ns/1ps
`default_nettype none

module spmd_tile (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              req_valid_i,
  input  spmd_pkg::req_op_e                 req_op_i,
  input  logic [spmd_pkg::WORD_IDX_W-1:0]   req_idx_i,
  input  logic [spmd_pkg::DATA_W-1:0]       req_wdata_i,
  output logic                              req_ready_o,
  output logic [spmd_pkg::DATA_W-1:0]       rdata_o,
  output logic                              done_o,
  output logic [spmd_pkg::DATA_W-1:0]       result_o
);

  logic [spmd_pkg::DATA_W-1:0]     mem_r [spmd_pkg::DMEM_WORDS];
  spmd_pkg::tile_state_e           state_r;
  logic [spmd_pkg::WORD_IDX_W-1:0] idx_r;
  logic [spmd_pkg::WORD_IDX_W-1:0] left_r;   // words still to add
  logic [spmd_pkg::DATA_W-1:0]     sum_r;
  logic                            host_acc;

  // host stalls while the kernel owns the memory
  assign req_ready_o = (state_r == spmd_pkg::T_IDLE) || (state_r == spmd_pkg::T_DONE);
  assign host_acc    = req_valid_i && req_ready_o;

  // host port, the only write path
  always_ff @(posedge clk_i) begin
    if (host_acc) begin
      if (req_op_i == spmd_pkg::REQ_STORE)
        mem_r[req_idx_i] <= req_wdata_i;
      else
        rdata_o <= mem_r[req_idx_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= spmd_pkg::T_IDLE;
      idx_r   <= '0;
      left_r  <= '0;
      sum_r   <= '0;
    end else begin
      case (state_r)
        spmd_pkg::T_IDLE: state_r <= spmd_pkg::T_LOAD_N;
        spmd_pkg::T_LOAD_N: begin
          left_r  <= mem_r[0][spmd_pkg::WORD_IDX_W-1:0]; // n fits in 6 bits
          idx_r   <= spmd_pkg::WORD_IDX_W'(1);
          sum_r   <= '0;
          state_r <= spmd_pkg::T_SUM;
        end
        spmd_pkg::T_SUM: begin
          if (left_r == '0) begin
            state_r <= spmd_pkg::T_DONE;
          end else begin
            sum_r  <= sum_r + mem_r[idx_r]; // wraps mod 2^32
            idx_r  <= idx_r + 1'b1;
            left_r <= left_r - 1'b1;
          end
        end
        default: state_r <= spmd_pkg::T_DONE; // hold until next reset
      endcase
    end
  end

  assign done_o   = (state_r == spmd_pkg::T_DONE);
  assign result_o = sum_r;

endmodule

`default_nettype wire

//--- verilog/spmd_tile_array.sv
// spmd tile array
// four tiles; requests steered by tile id, load data picked a cycle later
`timescale 1ns/1ps
`default_nettype none

module spmd_tile_array (
  input  logic                                            clk_i,
  input  logic                                            tile_reset_i,
  input  logic                                            req_valid_i,
  input  spmd_pkg::req_op_e                               req_op_i,
  input  logic [spmd_pkg::TILE_ID_W-1:0]                  req_tile_i,
  input  logic [spmd_pkg::WORD_IDX_W-1:0]                 req_idx_i,
  input  logic [spmd_pkg::DATA_W-1:0]                     req_wdata_i,
  output logic                                            req_ready_o,
  output logic                                            resp_valid_o,
  output logic [spmd_pkg::DATA_W-1:0]                     resp_rdata_o,
  output logic [spmd_pkg::NUM_TILES-1:0]                  done_mask_o,
  output logic [spmd_pkg::NUM_TILES*spmd_pkg::DATA_W-1:0] result_o
);

  logic [spmd_pkg::NUM_TILES-1:0] tile_valid;
  logic [spmd_pkg::NUM_TILES-1:0] tile_ready;
  logic [spmd_pkg::DATA_W-1:0]    tile_rdata [spmd_pkg::NUM_TILES];
  logic [spmd_pkg::TILE_ID_W-1:0] load_tile_r;
  logic                           req_acc;

  assign req_ready_o = tile_ready[req_tile_i];
  assign req_acc     = req_valid_i && req_ready_o;

  for (genvar k = 0; k < spmd_pkg::NUM_TILES; k++) begin : g_tile
    assign tile_valid[k] = req_valid_i && (req_tile_i == spmd_pkg::TILE_ID_W'(k));

    spmd_tile tile_inst (
      .clk_i       (clk_i),
      .reset_i     (tile_reset_i),
      .req_valid_i (tile_valid[k]),
      .req_op_i    (req_op_i),
      .req_idx_i   (req_idx_i),
      .req_wdata_i (req_wdata_i),
      .req_ready_o (tile_ready[k]),
      .rdata_o     (tile_rdata[k]),
      .done_o      (done_mask_o[k]),
      .result_o    (result_o[k*spmd_pkg::DATA_W +: spmd_pkg::DATA_W])
    );
  end

  // response one cycle after an accepted load
  always_ff @(posedge clk_i) begin
    resp_valid_o <= req_acc && (req_op_i == spmd_pkg::REQ_LOAD);
    if (req_acc)
      load_tile_r <= req_tile_i;
  end

  assign resp_rdata_o = tile_rdata[load_tile_r];

endmodule

`default_nettype wire

//--- verilog/spmd_run_ctrl.sv
// spmd run controller
// run enable, tile release chain and run cycle counter
`timescale 1ns/1ps
`default_nettype none

module spmd_run_ctrl (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           ctrl_wr_i,
  input  logic                           ctrl_wdata_i,
  input  logic [spmd_pkg::NUM_TILES-1:0] done_mask_i,
  output logic                           run_en_o,
  output logic                           tile_reset_o,
  output logic                           all_done_o,
  output logic [spmd_pkg::DATA_W-1:0]    cycles_o
);

  logic                             run_en_r;
  logic [spmd_pkg::RESET_DEPTH-1:0] rst_chain_r;
  logic                             run_rise;

  assign run_rise = ctrl_wr_i && ctrl_wdata_i && !run_en_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_en_r    <= 1'b0;
      rst_chain_r <= '1;   // tiles held
      cycles_o    <= '0;
    end else begin
      if (ctrl_wr_i)
        run_en_r <= ctrl_wdata_i;
      rst_chain_r <= {rst_chain_r[spmd_pkg::RESET_DEPTH-2:0], ~run_en_r};
      if (run_rise)
        cycles_o <= '0;
      else if (!tile_reset_o && !all_done_o)
        cycles_o <= cycles_o + 1'b1; // freezes once every tile is done
    end
  end

  assign run_en_o     = run_en_r;
  assign tile_reset_o = rst_chain_r[spmd_pkg::RESET_DEPTH-1];
  assign all_done_o   = &done_mask_i;

endmodule

`default_nettype wire

//--- verilog/spmd_host_bridge.sv
// spmd host bridge
// AXI4-Lite slave, one transaction at a time; decodes the register map,
// answers register accesses and forwards memory accesses to the tiles
`timescale 1ns/1ps
`default_nettype none

module spmd_host_bridge (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic [spmd_pkg::AXI_ADDR_W-1:0]                s_awaddr_i,
  input  logic                                           s_awvalid_i,
  output logic                                           s_awready_o,
  input  logic [spmd_pkg::DATA_W-1:0]                    s_wdata_i,
  input  logic [3:0]                                     s_wstrb_i,
  input  logic                                           s_wvalid_i,
  output logic                                           s_wready_o,
  output logic [1:0]                                     s_bresp_o,
  output logic                                           s_bvalid_o,
  input  logic                                           s_bready_i,
  input  logic [spmd_pkg::AXI_ADDR_W-1:0]                s_araddr_i,
  input  logic                                           s_arvalid_i,
  output logic                                           s_arready_o,
  output logic [spmd_pkg::DATA_W-1:0]                    s_rdata_o,
  output logic [1:0]                                     s_rresp_o,
  output logic                                           s_rvalid_o,
  input  logic                                           s_rready_i,
  output logic                                           req_valid_o,
  output spmd_pkg::req_op_e                              req_op_o,
  output logic [spmd_pkg::TILE_ID_W-1:0]                 req_tile_o,
  output logic [spmd_pkg::WORD_IDX_W-1:0]                req_idx_o,
  output logic [spmd_pkg::DATA_W-1:0]                    req_wdata_o,
  input  logic                                           req_ready_i,
  input  logic                                           resp_valid_i,
  input  logic [spmd_pkg::DATA_W-1:0]                    resp_rdata_i,
  output logic                                           ctrl_wr_o,
  output logic                                           ctrl_wdata_o,
  input  logic                                           run_en_i,
  input  logic                                           all_done_i,
  input  logic [spmd_pkg::NUM_TILES-1:0]                 done_mask_i,
  input  logic [spmd_pkg::DATA_W-1:0]                    cycles_i,
  input  logic [spmd_pkg::NUM_TILES*spmd_pkg::DATA_W-1:0] result_i
);

  spmd_pkg::bridge_state_e state_r;
  logic                        wr_acc;
  logic                        rd_acc;
  logic                        full_strb;
  logic                        aw_mem;
  logic                        ar_mem;
  logic                        reg_hit;
  logic [spmd_pkg::DATA_W-1:0] reg_rdata;

  assign wr_acc = (state_r == spmd_pkg::BR_IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_acc = (state_r == spmd_pkg::BR_IDLE) && s_arvalid_i && !wr_acc; // writes win

  assign s_awready_o = wr_acc;
  assign s_wready_o  = wr_acc;
  assign s_arready_o = rd_acc;

  assign full_strb = (s_wstrb_i == 4'hf); // only whole words are written
  assign aw_mem = (s_awaddr_i[11:10] == spmd_pkg::MEM_BASE[11:10]);
  assign ar_mem = (s_araddr_i[11:10] == spmd_pkg::MEM_BASE[11:10]);

  // run enable takes effect on the accept edge
  assign ctrl_wr_o    = wr_acc && full_strb && (s_awaddr_i == spmd_pkg::ADDR_CTRL);
  assign ctrl_wdata_o = s_wdata_i[0];

  always_comb begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    case (s_araddr_i)
      spmd_pkg::ADDR_CTRL:   reg_rdata[0] = run_en_i;
      spmd_pkg::ADDR_STATUS: begin
        reg_rdata[0]   = all_done_i;
        reg_rdata[7:4] = done_mask_i;
      end
      spmd_pkg::ADDR_CYCLES: reg_rdata = cycles_i;
      default: begin
        if (s_araddr_i[11:4] == spmd_pkg::ADDR_RESULT_BASE[11:4] && s_araddr_i[1:0] == 2'b00)
          reg_rdata = result_i[s_araddr_i[3:2]*spmd_pkg::DATA_W +: spmd_pkg::DATA_W];
        else
          reg_hit = 1'b0; // unmapped, data stays 0
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= spmd_pkg::BR_IDLE;
      req_valid_o <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_rvalid_o  <= 1'b0;
    end else begin
      case (state_r)
        spmd_pkg::BR_IDLE: begin
          if (wr_acc) begin
            if (aw_mem && full_strb && !run_en_i) begin
              req_valid_o <= 1'b1;
              req_op_o    <= spmd_pkg::REQ_STORE;
              req_tile_o  <= s_awaddr_i[9:8];
              req_idx_o   <= s_awaddr_i[7:2];
              req_wdata_o <= s_wdata_i;
              state_r     <= spmd_pkg::BR_WAIT_TILE;
            end else begin
              s_bvalid_o <= 1'b1;
              s_bresp_o  <= ctrl_wr_o ? spmd_pkg::RESP_OKAY : spmd_pkg::RESP_SLVERR;
              state_r    <= spmd_pkg::BR_WRESP;
            end
          end else if (rd_acc) begin
            if (ar_mem) begin
              req_valid_o <= 1'b1;
              req_op_o    <= spmd_pkg::REQ_LOAD;
              req_tile_o  <= s_araddr_i[9:8];
              req_idx_o   <= s_araddr_i[7:2];
              state_r     <= spmd_pkg::BR_WAIT_TILE;
            end else begin
              s_rvalid_o <= 1'b1;
              s_rdata_o  <= reg_rdata;
              s_rresp_o  <= reg_hit ? spmd_pkg::RESP_OKAY : spmd_pkg::RESP_SLVERR;
              state_r    <= spmd_pkg::BR_RRESP;
            end
          end
        end
        spmd_pkg::BR_WAIT_TILE: begin
          if (req_valid_o) begin
            if (req_ready_i) begin
              req_valid_o <= 1'b0;
              if (req_op_o == spmd_pkg::REQ_STORE) begin
                s_bvalid_o <= 1'b1;
                s_bresp_o  <= spmd_pkg::RESP_OKAY;
                state_r    <= spmd_pkg::BR_WRESP;
              end
            end
          end else if (resp_valid_i) begin // load data one cycle after transfer
            s_rvalid_o <= 1'b1;
            s_rdata_o  <= resp_rdata_i;
            s_rresp_o  <= spmd_pkg::RESP_OKAY;
            state_r    <= spmd_pkg::BR_RRESP;
          end
        end
        spmd_pkg::BR_WRESP: begin
          if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
            state_r    <= spmd_pkg::BR_IDLE;
          end
        end
        default: begin
          if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
            state_r    <= spmd_pkg::BR_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/spmd_cluster.sv
// spmd cluster top
// host bridge, run controller and tile array
`timescale 1ns/1ps
`default_nettype none

module spmd_cluster (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [spmd_pkg::AXI_ADDR_W-1:0] s_awaddr_i,
  input  logic                            s_awvalid_i,
  output logic                            s_awready_o,
  input  logic [spmd_pkg::DATA_W-1:0]     s_wdata_i,
  input  logic [3:0]                      s_wstrb_i,
  input  logic                            s_wvalid_i,
  output logic                            s_wready_o,
  output logic [1:0]                      s_bresp_o,
  output logic                            s_bvalid_o,
  input  logic                            s_bready_i,
  input  logic [spmd_pkg::AXI_ADDR_W-1:0] s_araddr_i,
  input  logic                            s_arvalid_i,
  output logic                            s_arready_o,
  output logic [spmd_pkg::DATA_W-1:0]     s_rdata_o,
  output logic [1:0]                      s_rresp_o,
  output logic                            s_rvalid_o,
  input  logic                            s_rready_i
);

  logic                                            req_valid;
  spmd_pkg::req_op_e                               req_op;
  logic [spmd_pkg::TILE_ID_W-1:0]                  req_tile;
  logic [spmd_pkg::WORD_IDX_W-1:0]                 req_idx;
  logic [spmd_pkg::DATA_W-1:0]                     req_wdata;
  logic                                            req_ready;
  logic                                            resp_valid;
  logic [spmd_pkg::DATA_W-1:0]                     resp_rdata;
  logic                                            ctrl_wr;
  logic                                            ctrl_wdata;
  logic                                            run_en;
  logic                                            tile_reset;
  logic                                            all_done;
  logic [spmd_pkg::NUM_TILES-1:0]                  done_mask;
  logic [spmd_pkg::DATA_W-1:0]                     cycles;
  logic [spmd_pkg::NUM_TILES*spmd_pkg::DATA_W-1:0] result;

  spmd_host_bridge bridge_inst (
    .clk_i, .reset_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .req_valid_o  (req_valid),
    .req_op_o     (req_op),
    .req_tile_o   (req_tile),
    .req_idx_o    (req_idx),
    .req_wdata_o  (req_wdata),
    .req_ready_i  (req_ready),
    .resp_valid_i (resp_valid),
    .resp_rdata_i (resp_rdata),
    .ctrl_wr_o    (ctrl_wr),
    .ctrl_wdata_o (ctrl_wdata),
    .run_en_i     (run_en),
    .all_done_i   (all_done),
    .done_mask_i  (done_mask),
    .cycles_i     (cycles),
    .result_i     (result)
  );

  spmd_run_ctrl run_ctrl_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ctrl_wr_i    (ctrl_wr),
    .ctrl_wdata_i (ctrl_wdata),
    .done_mask_i  (done_mask),
    .run_en_o     (run_en),
    .tile_reset_o (tile_reset),
    .all_done_o   (all_done),
    .cycles_o     (cycles)
  );

  spmd_tile_array tile_array_inst (
    .clk_i        (clk_i),
    .tile_reset_i (tile_reset),
    .req_valid_i  (req_valid),
    .req_op_i     (req_op),
    .req_tile_i   (req_tile),
    .req_idx_i    (req_idx),
    .req_wdata_i  (req_wdata),
    .req_ready_o  (req_ready),
    .resp_valid_o (resp_valid),
    .resp_rdata_o (resp_rdata),
    .done_mask_o  (done_mask),
    .result_o     (result)
  );

endmodule

`default_nettype wire

//--- bench/spmd_cluster_sva.sv
// spmd cluster protocol checks
// AXI handshake stability, response valids in reset and tile hold while stopped
`timescale 1ns/1ps
`default_nettype none

module spmd_cluster_sva (
  input logic clk_i,
  input logic reset_i,
  input logic awvalid_i,
  input logic awready_i,
  input logic wvalid_i,
  input logic wready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic run_en_i,
  input logic tile_reset_i
);

  int unsigned fail_count = 0; // assertion failures so far

  a_aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else begin
      $error("awvalid dropped before awready");
      fail_count++;
    end
  a_w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else begin
      $error("wvalid dropped before wready");
      fail_count++;
    end
  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end
  a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else begin
      $error("arvalid dropped before arready");
      fail_count++;
    end
  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  a_resp_reset: assert property (@(posedge clk_i)
    reset_i |=> !bvalid_i && !rvalid_i)
    else begin
      $error("response valid high after reset");
      fail_count++;
    end

  // chain plus the run enable register itself
  a_tile_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    !run_en_i [*spmd_pkg::RESET_DEPTH+1] |-> tile_reset_i)
    else begin
      $error("tiles released while run_en is low");
      fail_count++;
    end

endmodule

bind spmd_cluster spmd_cluster_sva sva_inst (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .awvalid_i    (s_awvalid_i),
  .awready_i    (s_awready_o),
  .wvalid_i     (s_wvalid_i),
  .wready_i     (s_wready_o),
  .bvalid_i     (s_bvalid_o),
  .bready_i     (s_bready_i),
  .arvalid_i    (s_arvalid_i),
  .arready_i    (s_arready_o),
  .rvalid_i     (s_rvalid_o),
  .rready_i     (s_rready_i),
  .run_en_i     (run_en),
  .tile_reset_i (tile_reset)
);

`default_nettype wire

//--- bench/spmd_cluster_tb.sv
// spmd cluster testbench
// AXI4-Lite host tasks, directed tests of memory access, kernel runs and run control
`timescale 1ns/1ps
`default_nettype none

module spmd_cluster_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int DRIVE_DELAY = 1;
  localparam int POLL_LIMIT  = 200;
  localparam int WORDS       = spmd_pkg::NUM_TILES * spmd_pkg::DMEM_WORDS;
  // store ~3 cycles, load ~4, register read ~2
  localparam int TEST_CYCLES = WORDS * 7 + 2 * (WORDS * 3 + POLL_LIMIT * 2 + 256) + 100;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD; // twice the expected length

  logic                            clk_i;
  logic                            reset_i;
  logic [spmd_pkg::AXI_ADDR_W-1:0] s_awaddr_i;
  logic                            s_awvalid_i;
  logic                            s_awready_o;
  logic [spmd_pkg::DATA_W-1:0]     s_wdata_i;
  logic [3:0]                      s_wstrb_i;
  logic                            s_wvalid_i;
  logic                            s_wready_o;
  logic [1:0]                      s_bresp_o;
  logic                            s_bvalid_o;
  logic                            s_bready_i;
  logic [spmd_pkg::AXI_ADDR_W-1:0] s_araddr_i;
  logic                            s_arvalid_i;
  logic                            s_arready_o;
  logic [spmd_pkg::DATA_W-1:0]     s_rdata_o;
  logic [1:0]                      s_rresp_o;
  logic                            s_rvalid_o;
  logic                            s_rready_i;

  logic [31:0] mem_model [spmd_pkg::NUM_TILES][spmd_pkg::DMEM_WORDS];
  logic [31:0] lcg_state = 32'h5027_1c9e;
  int          run_n [spmd_pkg::NUM_TILES]; // word 0 count per tile
  int          cycle_count = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  spmd_cluster spmd_cluster_inst (.*);

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [11:0] mem_addr(input int tile, input int word);
    return spmd_pkg::MEM_BASE + 12'(tile * 256) + 12'(word * 4);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errors++;
    $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
  endtask

  // entered and left DRIVE_DELAY after a rising edge
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    s_awaddr_i  = addr;
    s_awvalid_i = 1'b1;
    s_wdata_i   = data;
    s_wvalid_i  = 1'b1;
    @(negedge clk_i);
    while (!(s_awready_o && s_wready_o)) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b1;
    @(negedge clk_i);
    while (!s_bvalid_o) @(negedge clk_i);
    resp = s_bresp_o;
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [1:0] resp,
                          output logic [31:0] data);
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b1;
    @(negedge clk_i);
    while (!s_rvalid_o) @(negedge clk_i);
    resp = s_rresp_o;
    data = s_rdata_o;
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_rready_i = 1'b0;
  endtask

  task automatic test_reset_state();
    logic [1:0]  resp;
    logic [31:0] data;
    axi_read(spmd_pkg::ADDR_CTRL, resp, data);
    if (resp !== spmd_pkg::RESP_OKAY) report_mismatch("ctrl rresp", resp, spmd_pkg::RESP_OKAY);
    if (data !== 32'h0) report_mismatch("ctrl", data, 32'h0);
    axi_read(spmd_pkg::ADDR_STATUS, resp, data);
    if (resp !== spmd_pkg::RESP_OKAY) report_mismatch("status rresp", resp, spmd_pkg::RESP_OKAY);
    if (data !== 32'h0) report_mismatch("status", data, 32'h0);
    axi_read(12'h100, resp, data); // unmapped
    if (resp !== spmd_pkg::RESP_SLVERR)
      report_mismatch("unmapped rresp", resp, spmd_pkg::RESP_SLVERR);
    if (data !== 32'h0) report_mismatch("unmapped rdata", data, 32'h0);
    axi_write(12'h100, 32'h1, resp);
    if (resp !== spmd_pkg::RESP_SLVERR)
      report_mismatch("unmapped bresp", resp, spmd_pkg::RESP_SLVERR);
  endtask

  task automatic test_fill_readback();
    logic [1:0]  resp;
    logic [31:0] data;
    for (int t = 0; t < spmd_pkg::NUM_TILES; t++) begin
      for (int w = 0; w < spmd_pkg::DMEM_WORDS; w++) begin
        mem_model[t][w] = next_random();
        axi_write(mem_addr(t, w), mem_model[t][w], resp);
        if (resp !== spmd_pkg::RESP_OKAY)
          report_mismatch("store bresp", resp, spmd_pkg::RESP_OKAY);
      end
    end
    for (int t = 0; t < spmd_pkg::NUM_TILES; t++) begin
      for (int w = 0; w < spmd_pkg::DMEM_WORDS; w++) begin
        axi_read(mem_addr(t, w), resp, data);
        if (resp !== spmd_pkg::RESP_OKAY)
          report_mismatch("load rresp", resp, spmd_pkg::RESP_OKAY);
        if (data !== mem_model[t][w])
          report_mismatch($sformatf("tile%0d word%0d", t, w), data, mem_model[t][w]);
      end
    end
  endtask

  // tile 3 is still summing 63 words here
  task automatic check_busy_access();
    logic [1:0]  resp;
    logic [31:0] data;
    int          start_cyc;
    axi_write(mem_addr(3, 5), ~mem_model[3][5], resp);
    if (resp !== spmd_pkg::RESP_SLVERR)
      report_mismatch("run store bresp", resp, spmd_pkg::RESP_SLVERR);
    start_cyc = cycle_count;
    axi_read(mem_addr(3, 5), resp, data);
    if (cycle_count - start_cyc <= 4) begin
      other_errors++;
      $display("load from busy tile 3 completed without being stalled");
    end
    if (resp !== spmd_pkg::RESP_OKAY)
      report_mismatch("run load rresp", resp, spmd_pkg::RESP_OKAY);
    if (data !== mem_model[3][5]) report_mismatch("tile3 word5", data, mem_model[3][5]);
    axi_read(mem_addr(0, 0), resp, data);
    if (resp !== spmd_pkg::RESP_OKAY)
      report_mismatch("tile0 load rresp", resp, spmd_pkg::RESP_OKAY);
    if (data !== mem_model[0][0]) report_mismatch("tile0 word0", data, mem_model[0][0]);
  endtask

  task automatic test_kernel_run(input bit busy_access);
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] exp;
    int          start_cyc;
    int          elapsed;
    int          polls;
    for (int t = 0; t < spmd_pkg::NUM_TILES; t++) begin
      mem_model[t][0] = 32'(run_n[t]);
      for (int w = 1; w <= run_n[t]; w++)
        mem_model[t][w] = next_random();
      for (int w = 0; w <= run_n[t]; w++) begin
        axi_write(mem_addr(t, w), mem_model[t][w], resp);
        if (resp !== spmd_pkg::RESP_OKAY)
          report_mismatch("store bresp", resp, spmd_pkg::RESP_OKAY);
      end
    end
    start_cyc = cycle_count;
    axi_write(spmd_pkg::ADDR_CTRL, 32'h1, resp);
    if (resp !== spmd_pkg::RESP_OKAY) report_mismatch("ctrl bresp", resp, spmd_pkg::RESP_OKAY);
    if (busy_access)
      check_busy_access();
    polls = 0;
    data  = '0;
    while (!data[0] && polls < POLL_LIMIT) begin
      axi_read(spmd_pkg::ADDR_STATUS, resp, data);
      polls++;
    end
    elapsed = cycle_count - start_cyc;
    if (!data[0]) begin
      other_errors++;
      $display("all_done not seen after %0d STATUS polls", POLL_LIMIT);
    end
    if (data[7:4] !== 4'hf) report_mismatch("done mask", {28'h0, data[7:4]}, 32'hf);
    for (int t = 0; t < spmd_pkg::NUM_TILES; t++) begin
      exp = '0;
      for (int w = 1; w <= run_n[t]; w++)
        exp = exp + mem_model[t][w]; // wraps mod 2^32
      axi_read(spmd_pkg::ADDR_RESULT_BASE + 12'(4 * t), resp, data);
      if (data !== exp) report_mismatch($sformatf("result%0d", t), data, exp);
    end
    axi_read(spmd_pkg::ADDR_CYCLES, resp, data);
    if (data < 63 || data > elapsed) begin
      value_errors++;
      $display("FAIL %0t ns cycles got %0d expected 63 to %0d", $time, data, elapsed);
    end
  endtask

  task automatic test_stop_and_rerun();
    logic [1:0]  resp;
    logic [31:0] data;
    int          polls;
    axi_write(spmd_pkg::ADDR_CTRL, 32'h0, resp);
    polls = 0;
    data  = 32'hffff_ffff;
    while (data !== 32'h0 && polls < 16) begin // waits out the release chain
      axi_read(spmd_pkg::ADDR_STATUS, resp, data);
      polls++;
    end
    if (data !== 32'h0) report_mismatch("status after stop", data, 32'h0);
    axi_read(spmd_pkg::ADDR_CTRL, resp, data);
    if (data !== 32'h0) report_mismatch("ctrl after stop", data, 32'h0);
    run_n = '{5, 63, 0, 40};
    test_kernel_run(1'b0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    reset_i     = 1'b1;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = 4'hf;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    test_reset_state();
    test_fill_readback();
    run_n = '{0, 1, 17, 63};
    test_kernel_run(1'b1);
    test_stop_and_rerun();
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errors, other_errors, spmd_cluster_inst.sva_inst.fail_count);
    if (value_errors == 0 && other_errors == 0 && spmd_cluster_inst.sva_inst.fail_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/spmd_pkg.sv
verilog/spmd_tile.sv
verilog/spmd_tile_array.sv
verilog/spmd_run_ctrl.sv
verilog/spmd_host_bridge.sv
verilog/spmd_cluster.sv
bench/spmd_cluster_sva.sv
bench/spmd_cluster_tb.sv
